/* verilog/uart_pkg.sv */
// --------------------
// Shared PI1 bus and UART receive definitions.
// --------------------
package uart_pkg;

	localparam int ARCH_BITS = 32;
	localparam int ADDR_BITS = ARCH_BITS - 2; // Word address without the byte bits.
	localparam int SEL_BITS  = ARCH_BITS / 8;
	localparam int BYTE_BITS = 8;

	typedef logic [1:0]           pi1_op_t;
	typedef logic [ARCH_BITS-1:0] arch_data_t;
	typedef logic [SEL_BITS-1:0]  pi1_sel_t;
	typedef logic [ADDR_BITS-1:0] pi1_addr_t;
	typedef logic [BYTE_BITS-1:0] byte_t;

	// PI1 operation codes.
	localparam pi1_op_t PI1_NOP = 2'b00;
	localparam pi1_op_t PI1_WR  = 2'b01;
	localparam pi1_op_t PI1_RD  = 2'b10;
	localparam pi1_op_t PI1_RW  = 2'b11;

	// Only the lowest word address bit is decoded.
	localparam logic REG_DATA   = 1'b0;
	localparam logic REG_STATUS = 1'b1;

	// Status word layout with the count in the low bits.
	localparam int STAT_OVERRUN_BIT = 31;
	localparam int STAT_FRAMING_BIT = 30;

	// Set in a data read that returned a byte.
	localparam int DATA_VALID_BIT = 8;

	// Byte lane holding both flags.
	localparam int CLR_SEL_BIT = 3;

endpackage

/* verilog/uart_rx_phy.sv */
// --------------------
// UART receive phy that samples the rx line mid-bit into bytes.
// --------------------
`timescale 1ns/1ns

module uart_rx_phy
	import uart_pkg::*;
#(
	parameter int CLKFREQ  = 100000000,
	parameter int BAUDRATE = 6250000
) (
	input  logic  clk100mhz,
	input  logic  rst_p,
	input  logic  rx_i,
	output logic  byte_valid_o,
	output byte_t byte_data_o,
	output logic  frame_err_o
);

	localparam int CLKS_PER_BIT = CLKFREQ / BAUDRATE;
	localparam int CNT_W        = $clog2(CLKS_PER_BIT);

	localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t        state;
	logic [CNT_W-1:0] bit_cnt;
	logic [2:0]       bit_idx;
	logic             rx_meta;
	logic             rx_sync;
	logic             rx_last;
	logic             bit_tick;
	byte_t            shreg;

	assign bit_tick    = (bit_cnt == BIT_LAST);
	assign byte_data_o = shreg; // Stable from stop sample to next frame.

	always_ff @(posedge clk100mhz) begin
		if (rst_p) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_last <= 1'b1;
		end else begin
			rx_meta <= rx_i;
			rx_sync <= rx_meta;
			rx_last <= rx_sync;
		end
	end

	always_ff @(posedge clk100mhz) begin
		if (state == RX_DATA && bit_tick)
			shreg <= {rx_sync, shreg[7:1]}; // LSB first.
	end

	always_ff @(posedge clk100mhz) begin
		if (rst_p) begin
			state        <= RX_IDLE;
			bit_cnt      <= '0;
			bit_idx      <= '0;
			byte_valid_o <= 1'b0;
			frame_err_o  <= 1'b0;
		end else begin
			byte_valid_o <= 1'b0;
			frame_err_o  <= 1'b0;
			bit_cnt      <= bit_cnt + 1'b1;
			case (state)
			RX_IDLE: begin
				bit_cnt <= '0;
				// Start on a falling edge so a held low line never restarts a frame.
				if (rx_last && !rx_sync)
					state <= RX_START;
			end
			RX_START: begin
				if (bit_cnt == HALF_LAST) begin
					bit_cnt <= '0;
					bit_idx <= '0;
					state   <= rx_sync ? RX_IDLE : RX_DATA; // Glitch check.
				end
			end
			RX_DATA: begin
				if (bit_tick) begin
					bit_cnt <= '0;
					bit_idx <= bit_idx + 1'b1;
					if (bit_idx == 3'd7)
						state <= RX_STOP;
				end
			end
			RX_STOP: begin
				if (bit_tick) begin
					byte_valid_o <= rx_sync;
					frame_err_o  <= !rx_sync;
					state        <= RX_IDLE;
				end
			end
			default: state <= RX_IDLE;
			endcase
		end
	end

endmodule

/* verilog/uart_rx_fifo.sv */
// --------------------
// First-word-fall-through receive byte buffer.
// --------------------
`timescale 1ns/1ns

module uart_rx_fifo
	import uart_pkg::*;
#(
	parameter int BUFSZ = 8
) (
	input  logic                   clk100mhz,
	input  logic                   rst_p,
	input  logic                   push_i,
	input  byte_t                  push_data_i,
	input  logic                   pop_i,
	output byte_t                  rd_data_o,
	output logic [$clog2(BUFSZ):0] count_o,
	output logic                   full_o
);

	localparam int AW = $clog2(BUFSZ);

	localparam logic [AW:0] FULL_COUNT = (AW + 1)'(BUFSZ);

	byte_t         mem [BUFSZ];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic          do_push;
	logic          do_pop;

	assign full_o    = (count_o == FULL_COUNT);
	assign do_push   = push_i && !full_o;
	assign do_pop    = pop_i && (count_o != '0);
	assign rd_data_o = mem[rd_ptr]; // Oldest byte.

	always_ff @(posedge clk100mhz) begin
		if (do_push)
			mem[wr_ptr] <= push_data_i;
	end

	always_ff @(posedge clk100mhz) begin
		if (rst_p) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count_o <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
			2'b10:   count_o <= count_o + 1'b1;
			2'b01:   count_o <= count_o - 1'b1;
			default: count_o <= count_o;
			endcase
		end
	end

endmodule

/* verilog/uart_pi1_regs.sv */
// --------------------
// PI1 slave for the receive buffer, status flags and interrupt.
// --------------------
`timescale 1ns/1ns

module uart_pi1_regs
	import uart_pkg::*;
#(
	parameter int BUFSZ = 8
) (
	input  logic                   clk100mhz,
	input  logic                   rst_p,
	input  pi1_op_t                pi1_op_i,
	input  pi1_addr_t              pi1_addr_i,
	input  arch_data_t             pi1_data_i,
	input  pi1_sel_t               pi1_sel_i,
	output arch_data_t             pi1_data_o,
	output logic                   pi1_rdy_o,
	input  logic                   byte_valid_i,
	input  logic                   frame_err_i,
	input  logic                   full_i,
	input  byte_t                  rd_data_i,
	input  logic [$clog2(BUFSZ):0] count_i,
	output logic                   pop_o,
	input  logic                   intrdy_i,
	output logic                   intrqst_o
);

	localparam int CW = $clog2(BUFSZ) + 1;

	pi1_op_t    op_q;
	logic       word_q;
	logic       clr_q;
	arch_data_t wdata_q;
	logic       overrun_q;
	logic       framing_q;
	logic       accept;
	logic       busy;
	logic       is_rd;
	logic       is_wr;
	logic       has_byte;
	logic       clear;
	arch_data_t status_w;
	arch_data_t data_w;
	arch_data_t result_w;

	assign accept   = (pi1_op_i != PI1_NOP) && pi1_rdy_o;
	assign busy     = !pi1_rdy_o;
	assign is_rd    = (op_q == PI1_RD) || (op_q == PI1_RW);
	assign is_wr    = (op_q == PI1_WR) || (op_q == PI1_RW);
	assign has_byte = (count_i != '0);

	assign clear = busy && is_wr && (word_q == REG_STATUS) && clr_q;
	assign pop_o = busy && is_rd && (word_q == REG_DATA) && has_byte;

	assign intrqst_o = has_byte && intrdy_i;

	always_comb begin
		status_w                   = '0;
		status_w[STAT_OVERRUN_BIT] = overrun_q;
		status_w[STAT_FRAMING_BIT] = framing_q;
		status_w[CW-1:0]           = count_i;
		data_w                     = '0;
		if (has_byte) begin
			data_w[DATA_VALID_BIT]  = 1'b1;
			data_w[BYTE_BITS-1:0]   = rd_data_i;
		end
		if (is_rd)
			result_w = (word_q == REG_STATUS) ? status_w : data_w;
		else
			result_w = wdata_q; // Plain writes echo the written word.
	end

	// Request is captured at acceptance and held through the busy cycle.
	always_ff @(posedge clk100mhz) begin
		if (accept) begin
			op_q    <= pi1_op_i;
			word_q  <= pi1_addr_i[0];
			clr_q   <= pi1_sel_i[CLR_SEL_BIT];
			wdata_q <= pi1_data_i;
		end
	end

	always_ff @(posedge clk100mhz) begin
		if (busy)
			pi1_data_o <= result_w;
	end

	always_ff @(posedge clk100mhz) begin
		if (rst_p) begin
			pi1_rdy_o <= 1'b1;
			overrun_q <= 1'b0;
			framing_q <= 1'b0;
		end else begin
			pi1_rdy_o <= !accept; // One busy cycle per operation.
			if (clear) begin
				overrun_q <= 1'b0;
				framing_q <= 1'b0;
			end
			// A new error wins over a clear in the same cycle.
			if (byte_valid_i && full_i)
				overrun_q <= 1'b1;
			if (frame_err_i)
				framing_q <= 1'b1;
		end
	end

endmodule

/* verilog/uart_rx_pi1.sv */
// --------------------
// UART receive path with a PI1 register port.
// --------------------
`timescale 1ns/1ns

module uart_rx_pi1
	import uart_pkg::*;
#(
	parameter int CLKFREQ  = 100000000,
	parameter int BAUDRATE = 6250000,
	parameter int BUFSZ    = 8
) (
	input  logic       clk100mhz,
	input  logic       rst_p,
	input  logic       rx_i,
	input  pi1_op_t    pi1_op_i,
	input  pi1_addr_t  pi1_addr_i,
	input  arch_data_t pi1_data_i,
	input  pi1_sel_t   pi1_sel_i,
	output arch_data_t pi1_data_o,
	output logic       pi1_rdy_o,
	output logic       intrqst_o,
	input  logic       intrdy_i
);

	logic                   byte_valid;
	byte_t                  byte_data;
	logic                   frame_err;
	logic                   pop;
	byte_t                  rd_data;
	logic [$clog2(BUFSZ):0] count;
	logic                   full;

	uart_rx_phy #(
		.CLKFREQ  (CLKFREQ),
		.BAUDRATE (BAUDRATE)
	) u_phy (
		.clk100mhz    (clk100mhz),
		.rst_p        (rst_p),
		.rx_i         (rx_i),
		.byte_valid_o (byte_valid),
		.byte_data_o  (byte_data),
		.frame_err_o  (frame_err)
	);

	uart_rx_fifo #(
		.BUFSZ (BUFSZ)
	) u_fifo (
		.clk100mhz   (clk100mhz),
		.rst_p       (rst_p),
		.push_i      (byte_valid),
		.push_data_i (byte_data),
		.pop_i       (pop),
		.rd_data_o   (rd_data),
		.count_o     (count),
		.full_o      (full)
	);

	uart_pi1_regs #(
		.BUFSZ (BUFSZ)
	) u_regs (
		.clk100mhz    (clk100mhz),
		.rst_p        (rst_p),
		.pi1_op_i     (pi1_op_i),
		.pi1_addr_i   (pi1_addr_i),
		.pi1_data_i   (pi1_data_i),
		.pi1_sel_i    (pi1_sel_i),
		.pi1_data_o   (pi1_data_o),
		.pi1_rdy_o    (pi1_rdy_o),
		.byte_valid_i (byte_valid),
		.frame_err_i  (frame_err),
		.full_i       (full),
		.rd_data_i    (rd_data),
		.count_i      (count),
		.pop_o        (pop),
		.intrdy_i     (intrdy_i),
		.intrqst_o    (intrqst_o)
	);

endmodule

/* verification/uart_rx_pi1_chk.sv */
// --------------------
// Bound PI1 handshake and buffer checks.
// --------------------
`timescale 1ns/1ns

module uart_rx_pi1_chk
	import uart_pkg::*;
#(
	parameter int BUFSZ = 8
) (
	input logic                   clk100mhz,
	input logic                   rst_p,
	input pi1_op_t                pi1_op_i,
	input logic                   pi1_rdy_i,
	input logic                   pop_i,
	input logic [$clog2(BUFSZ):0] count_i
);

	int fail_cnt = 0;

	rdy_busy_once: assert property (@(posedge clk100mhz) disable iff (rst_p)
		(pi1_op_i != PI1_NOP && pi1_rdy_i) |=> !pi1_rdy_i ##1 pi1_rdy_i)
	else begin
		$error("PI1 ready not low for exactly one cycle after an accepted operation");
		fail_cnt++;
	end

	no_pop_empty: assert property (@(posedge clk100mhz) disable iff (rst_p)
		pop_i |-> (count_i != '0))
	else begin
		$error("Buffer pop while empty");
		fail_cnt++;
	end

	count_bound: assert property (@(posedge clk100mhz) disable iff (rst_p)
		count_i <= BUFSZ)
	else begin
		$error("Buffer count above its size");
		fail_cnt++;
	end

endmodule

bind uart_rx_pi1 uart_rx_pi1_chk #(
	.BUFSZ (BUFSZ)
) u_chk (
	.clk100mhz (clk100mhz),
	.rst_p     (rst_p),
	.pi1_op_i  (pi1_op_i),
	.pi1_rdy_i (pi1_rdy_o),
	.pop_i     (pop),
	.count_i   (count)
);

/* verification/uart_rx_pi1_tb.sv */
// --------------------
// Testbench for the UART receive path, pattern driven.
// --------------------
`timescale 1ns/1ns

module uart_rx_pi1_tb
	import uart_pkg::*;
();

	localparam int CLKFREQ   = 100000000;
	localparam int BAUDRATE  = 6250000;
	localparam int BUFSZ     = 8;
	localparam int BIT_CLKS  = CLKFREQ / BAUDRATE;
	localparam int MAX_PATS  = 64;
	localparam int RDY_LIMIT = 8;

	localparam logic [3:0] CMD_GOOD    = 4'h0;
	localparam logic [3:0] CMD_BAD     = 4'h1;
	localparam logic [3:0] CMD_RD_DATA = 4'h2;
	localparam logic [3:0] CMD_RD_STAT = 4'h3;
	localparam logic [3:0] CMD_CLEAR   = 4'h4;
	localparam logic [3:0] CMD_IRQ     = 4'h5;
	localparam logic [3:0] CMD_END     = 4'hf;

	logic       clk100mhz;
	logic       rst_p;
	logic       rx_i;
	pi1_op_t    pi1_op_i;
	pi1_addr_t  pi1_addr_i;
	arch_data_t pi1_data_i;
	pi1_sel_t   pi1_sel_i;
	arch_data_t pi1_data_o;
	logic       pi1_rdy_o;
	logic       intrqst_o;
	logic       intrdy_i;

	logic [43:0] pats [MAX_PATS]; // Kind, byte, expected value.
	int          num_pats;
	logic        pats_ready;
	logic        frame_pending;

	uart_rx_pi1 #(
		.CLKFREQ  (CLKFREQ),
		.BAUDRATE (BAUDRATE),
		.BUFSZ    (BUFSZ)
	) DUT (
		.clk100mhz  (clk100mhz),
		.rst_p      (rst_p),
		.rx_i       (rx_i),
		.pi1_op_i   (pi1_op_i),
		.pi1_addr_i (pi1_addr_i),
		.pi1_data_i (pi1_data_i),
		.pi1_sel_i  (pi1_sel_i),
		.pi1_data_o (pi1_data_o),
		.pi1_rdy_o  (pi1_rdy_o),
		.intrqst_o  (intrqst_o),
		.intrdy_i   (intrdy_i)
	);

	initial begin
		clk100mhz = 1'b0;
		forever #5 clk100mhz = ~clk100mhz;
	end

	task automatic abort_run();
		$display("TESTBENCH FAILED");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic check_data(input arch_data_t got, input arch_data_t exp);
		if (got !== exp) begin
			$display("FAILED at %0t ns: data read %h, expected %h", $time, got, exp);
			abort_run();
		end
	endtask

	task automatic check_status(input arch_data_t got, input arch_data_t exp);
		if (got !== exp) begin
			$display("FAILED at %0t ns: status read %h, expected %h", $time, got, exp);
			abort_run();
		end
	endtask

	task automatic check_irq(input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAILED at %0t ns: intrqst %b, expected %b", $time, got, exp);
			abort_run();
		end
	endtask

	task automatic drive_bit(input logic level);
		@(posedge clk100mhz);
		rx_i <= level;
		repeat (BIT_CLKS - 1) @(posedge clk100mhz);
	endtask

	task automatic send_frame(input byte_t data, input logic stop_level);
		int i;
		int gap;
		drive_bit(1'b0);
		for (i = 0; i < 8; i++)
			drive_bit(data[i]); // LSB first.
		drive_bit(stop_level);
		if (!stop_level)
			drive_bit(1'b1); // Line must rise before the next start edge.
		gap = $urandom % 4;
		repeat (gap) drive_bit(1'b1);
		frame_pending = 1'b1;
	endtask

	// Give the last frame time to land in the buffer.
	task automatic settle_frames();
		if (frame_pending)
			repeat (10 * BIT_CLKS) @(posedge clk100mhz);
		frame_pending = 1'b0;
	endtask

	task automatic pi1_access(input pi1_op_t op, input logic word, input pi1_sel_t sel,
			output arch_data_t rdata);
		int waited;
		waited = 0;
		@(negedge clk100mhz);
		while (!pi1_rdy_o) begin
			waited++;
			if (waited > RDY_LIMIT) begin
				$display("PI1 port stayed busy before a new request");
				abort_run();
			end
			@(negedge clk100mhz);
		end
		@(posedge clk100mhz);
		pi1_op_i   <= op;
		pi1_addr_i <= pi1_addr_t'(word);
		pi1_data_i <= '0;
		pi1_sel_i  <= sel;
		@(posedge clk100mhz); // Accepted here.
		pi1_op_i  <= PI1_NOP;
		pi1_sel_i <= '0;
		waited = 0;
		@(negedge clk100mhz);
		while (!pi1_rdy_o) begin
			waited++;
			if (waited > RDY_LIMIT) begin
				$display("PI1 ready did not return after a request");
				abort_run();
			end
			@(negedge clk100mhz);
		end
		rdata = pi1_data_o;
	endtask

	task automatic run_pattern(input logic [43:0] pat);
		logic [3:0] kind;
		byte_t      pat_byte;
		arch_data_t exp_val;
		arch_data_t rdata;
		pi1_sel_t   clr_sel;
		kind     = pat[43:40];
		pat_byte = pat[39:32];
		exp_val  = pat[31:0];
		clr_sel  = '0;
		clr_sel[CLR_SEL_BIT] = 1'b1;
		case (kind)
		CMD_GOOD: send_frame(pat_byte, 1'b1);
		CMD_BAD:  send_frame(pat_byte, 1'b0);
		CMD_RD_DATA: begin
			settle_frames();
			pi1_access(PI1_RD, REG_DATA, '0, rdata);
			check_data(rdata, exp_val);
		end
		CMD_RD_STAT: begin
			settle_frames();
			pi1_access(PI1_RD, REG_STATUS, '0, rdata);
			check_status(rdata, exp_val);
		end
		CMD_CLEAR: begin
			settle_frames();
			pi1_access(PI1_WR, REG_STATUS, clr_sel, rdata);
		end
		CMD_IRQ: begin
			settle_frames();
			@(posedge clk100mhz);
			intrdy_i <= pat_byte[0];
			@(negedge clk100mhz);
			check_irq(intrqst_o, exp_val[0]);
		end
		default: begin
			$display("Unknown command %h in the pattern file", kind);
			abort_run();
		end
		endcase
	endtask

	initial begin
		int limit;
		wait (pats_ready);
		limit = num_pats * 14 * BIT_CLKS + 1000;
		repeat (limit) @(posedge clk100mhz);
		$display("Run timed out after %0d cycles", limit);
		abort_run();
	end

	initial begin
		int i;
		rst_p         = 1'b1;
		rx_i          = 1'b1;
		pi1_op_i      = PI1_NOP;
		pi1_addr_i    = '0;
		pi1_data_i    = '0;
		pi1_sel_i     = '0;
		intrdy_i      = 1'b0;
		frame_pending = 1'b0;
		pats_ready    = 1'b0;
		num_pats      = 0;
		void'($urandom(32'h824521b6));
		$readmemh("verification/uart_rx_patterns.mem", pats);
		while (num_pats < MAX_PATS && !$isunknown(pats[num_pats])
				&& pats[num_pats][43:40] != CMD_END)
			num_pats++;
		if (num_pats == 0) begin
			$display("No patterns were loaded from the pattern file");
			abort_run();
		end
		pats_ready = 1'b1;
		repeat (16) @(posedge clk100mhz);
		rst_p <= 1'b0;
		@(posedge clk100mhz);
		for (i = 0; i < num_pats; i++)
			run_pattern(pats[i]);
		repeat (4) @(posedge clk100mhz);
		if (DUT.u_chk.fail_cnt == 0) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			$display("Assertion checks failed %0d times", DUT.u_chk.fail_cnt);
			abort_run();
		end
	end

endmodule

/* uart_rx_pi1.f */
verilog/uart_pkg.sv
verilog/uart_rx_phy.sv
verilog/uart_rx_fifo.sv
verilog/uart_pi1_regs.sv
verilog/uart_rx_pi1.sv
verification/uart_rx_pi1_chk.sv
verification/uart_rx_pi1_tb.sv

/* verification/uart_rx_patterns.mem */
// Columns: kind (1 hex digit), byte (2 hex digits), expected value (8 hex digits).
// Kinds: 0 good frame, 1 low stop bit, 2 read data, 3 read status, 4 clear, 5 irq, F end.
20000000000 // Empty buffer reads zero.
05500000000
0A300000000
30000000002 // Two bytes queued.
50100000001
50000000000 // Request masked by intrdy.
50100000001
20000000155
200000001A3
50100000000 // Empty again.
13C00000000 // Stop bit low.
30040000000
40000000000
30000000000
00100000000
00200000000
00300000000
00400000000
00500000000
00600000000
00700000000
00800000000
00900000000
00A00000000
30080000008 // Full with overrun.
50100000001
40000000000
30000000008 // Flags cleared, count kept.
20000000101
20000000102
20000000103
20000000104
20000000105
20000000106
20000000107
20000000108
20000000000
30000000000
F0000000000
